// File: build.f
+incdir+.
isa_pkg.sv
mem_pkg.sv
memory_access_stage.sv
line_arbiter.sv
line_memory.sv
mem_subsystem.sv
tb_mem_subsystem.sv

// File: isa_pkg.sv
/*
 * Instruction field view, memory op-type encoding
 * and control register indices of the core
 */
`default_nettype none

package isa_pkg;
	// Op-type field of a format C instruction
	typedef enum logic [3:0] {
		OP_BYTE_U		= 4'd0,
		OP_BYTE_S		= 4'd1,
		OP_HALF_U		= 4'd2,
		OP_HALF_S		= 4'd3,
		OP_WORD			= 4'd4,
		OP_WORD_SYNC	= 4'd5,
		OP_WORD_CR		= 4'd6,	// Control register transfer
		OP_BLOCK		= 4'd7,
		OP_BLOCK_M		= 4'd8,
		OP_BLOCK_IM		= 4'd9,
		OP_STRIDED		= 4'd10,
		OP_STRIDED_M	= 4'd11,
		OP_STRIDED_IM	= 4'd12,
		OP_SCGATH		= 4'd13,
		OP_SCGATH_M		= 4'd14,
		OP_SCGATH_IM	= 4'd15
	} mem_op_e;

	typedef struct packed {
		logic [1:0]		format;
		logic			load;
		mem_op_e		op;
		logic [19:0]	other;
		logic [4:0]		cr_index;
	} instr_t;

	localparam logic [1:0] FMT_C = 2'b10;

	localparam logic [4:0] CR_STRAND_ID	= 5'd0;
	localparam logic [4:0] CR_TEST		= 5'd7;
	localparam logic [4:0] CR_STRAND_EN	= 5'd30;
	localparam logic [4:0] CR_HALT		= 5'd31;
endpackage

`default_nettype wire

// File: line_arbiter.sv
/*
 * Fixed-priority line arbiter, stage over host,
 * with a one-cycle owner flag for read data
 */
`default_nettype none

module line_arbiter
#(
	parameter type req_t = logic
)
(
	input  logic	clk,
	input  logic	arst_n_i,
	input  req_t	stage_req_i,
	input  logic	stage_access_i,
	input  logic	host_req_i,
	input  req_t	host_line_i,
	output req_t	mem_req_o,
	output logic	mem_en_o,
	output logic	host_gnt_o,
	output logic	host_rvalid_o
);
	// Stage cannot stall, so it always wins
	assign host_gnt_o = host_req_i && !stage_access_i;
	assign mem_en_o = stage_access_i || host_req_i;
	assign mem_req_o = stage_access_i ? stage_req_i : host_line_i;

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			host_rvalid_o <= 1'b0;
		else
			host_rvalid_o <= host_gnt_o;	// Host owned last access
	end

	a_stage_first: assert property (@(posedge clk) disable iff (!arst_n_i)
		stage_access_i |-> !host_gnt_o ##1 !host_rvalid_o);

	a_rvalid_after_gnt: assert property (@(posedge clk) disable iff (!arst_n_i)
		host_gnt_o |=> host_rvalid_o);

	a_rvalid_only_after_gnt: assert property (@(posedge clk) disable iff (!arst_n_i)
		!host_gnt_o |=> !host_rvalid_o);
endmodule

`default_nettype wire

// File: line_memory.sv
/*
 * Line-wide data memory, byte write mask, registered read
 */
`default_nettype none

`include "mem_defs.svh"

module line_memory
	import mem_pkg::*;
(
	input  logic						clk,
	input  logic						en_i,
	input  line_req_t					req_i,
	output logic [`MEM_LINE_BITS-1:0]	rdata_o
);
	localparam int IDX_BITS = $clog2(`MEM_DEPTH_LINES);
	localparam int BYTES = `MEM_LINE_BITS / 8;

	logic [`MEM_LINE_BITS-1:0]	lines_q [`MEM_DEPTH_LINES];
	logic [IDX_BITS-1:0]		idx;

	assign idx = req_i.addr[IDX_BITS-1:0];	// Upper address bits alias

	always_ff @(posedge clk)
	begin
		if (en_i)
		begin
			if (req_i.write)
			begin
				for (int b = 0; b < BYTES; b++)
				begin
					if (req_i.mask[b])
						lines_q[idx][b*8 +: 8] <= req_i.data[b*8 +: 8];
				end
			end
			rdata_o <= lines_q[idx];	// Old data on a write
		end
	end
endmodule

`default_nettype wire

// File: mem_defs.svh
/*
 * Sizing macros for the memory slice of the vector core:
 * cache line width, lanes per line, memory depth, core ID width
 */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// One cache line holds a full vector register
`define MEM_LINE_BITS		512

// 32-bit lanes per line
`define MEM_LANES			16

// Lines in the modelled data memory
`define MEM_DEPTH_LINES		64

// Core ID field, padded with the strand number to 32 bits
`define MEM_CORE_ID_BITS	30

`endif

// File: mem_pkg.sv
/*
 * Line request and stage result structs
 * shared by the stage, arbiter, line memory and top level
 */
`default_nettype none

`include "mem_defs.svh"

package mem_pkg;
	import isa_pkg::*;

	// One access to a whole cache line
	typedef struct packed {
		logic [25:0]					addr;	// Line address, byte address bits 31:6
		logic							write;
		logic [`MEM_LINE_BITS/8-1:0]	mask;
		logic [`MEM_LINE_BITS-1:0]		data;
	} line_req_t;

	// Fields handed on to writeback
	typedef struct packed {
		instr_t							instruction;
		logic [1:0]						strand;
		logic [31:0]					pc;
		logic [`MEM_LINE_BITS-1:0]		result;
		logic [`MEM_LANES-1:0]			mask;
		logic [6:0]						writeback_reg;
		logic							is_vector;
		logic							has_writeback;
		logic [3:0]						reg_lane;
		logic [3:0]						cache_lane;
		logic [31:0]					strided_offset;
		logic							was_access;
	} stage_out_t;
endpackage

`default_nettype wire

// File: mem_subsystem.sv
/*
 * Top level: memory access stage and host port
 * sharing one line memory through the line arbiter
 */
`default_nettype none

`include "mem_defs.svh"

module mem_subsystem
	import isa_pkg::*, mem_pkg::*;
#(
	parameter logic [`MEM_CORE_ID_BITS-1:0] CORE_ID = '0
)
(
	input  logic						clk,
	input  logic						arst_n_i,
	input  logic						flush_i,
	input  instr_t						instruction_i,
	input  logic [1:0]					strand_i,
	input  logic [31:0]					pc_i,
	input  logic [`MEM_LINE_BITS-1:0]	store_value_i,
	input  logic [`MEM_LINE_BITS-1:0]	result_i,
	input  logic [`MEM_LANES-1:0]		mask_i,
	input  logic						has_writeback_i,
	input  logic [6:0]					writeback_reg_i,
	input  logic						writeback_is_vector_i,
	input  logic [3:0]					reg_lane_select_i,
	input  logic [31:0]					strided_offset_i,
	input  logic [31:0]					base_addr_i,
	output line_req_t					req_o,
	output logic						access_o,
	output logic						synchronized_o,
	output stage_out_t					stage_o,
	output logic [3:0]					strand_enable_o,
	input  logic						host_req_i,
	input  line_req_t					host_line_i,
	output logic						host_gnt_o,
	output logic						host_rvalid_o,
	output logic [`MEM_LINE_BITS-1:0]	host_rdata_o,
	output logic [`MEM_LINE_BITS-1:0]	load_line_o
);
	line_req_t					mem_req;
	logic						mem_en;
	logic [`MEM_LINE_BITS-1:0]	rdata;

	memory_access_stage #(.CORE_ID(CORE_ID)) u_stage (
		.clk					(clk),
		.arst_n_i				(arst_n_i),
		.flush_i				(flush_i),
		.instruction_i			(instruction_i),
		.strand_i				(strand_i),
		.pc_i					(pc_i),
		.store_value_i			(store_value_i),
		.result_i				(result_i),
		.mask_i					(mask_i),
		.has_writeback_i		(has_writeback_i),
		.writeback_reg_i		(writeback_reg_i),
		.writeback_is_vector_i	(writeback_is_vector_i),
		.reg_lane_select_i		(reg_lane_select_i),
		.strided_offset_i		(strided_offset_i),
		.base_addr_i			(base_addr_i),
		.req_o					(req_o),
		.access_o				(access_o),
		.synchronized_o			(synchronized_o),
		.stage_o				(stage_o),
		.strand_enable_o		(strand_enable_o)
	);

	line_arbiter #(.req_t(line_req_t)) u_arb (
		.clk			(clk),
		.arst_n_i		(arst_n_i),
		.stage_req_i	(req_o),
		.stage_access_i	(access_o),
		.host_req_i		(host_req_i),
		.host_line_i	(host_line_i),
		.mem_req_o		(mem_req),
		.mem_en_o		(mem_en),
		.host_gnt_o		(host_gnt_o),
		.host_rvalid_o	(host_rvalid_o)
	);

	line_memory u_mem (
		.clk		(clk),
		.en_i		(mem_en),
		.req_i		(mem_req),
		.rdata_o	(rdata)
	);

	// Same registered line, qualified by host_rvalid_o or stage_o.was_access
	assign host_rdata_o = rdata;
	assign load_line_o = rdata;
endmodule

`default_nettype wire

// File: memory_access_stage.sv
/*
 * Memory access stage: line address and lane generation, store
 * alignment, byte write mask, control registers, writeback registers
 */
`default_nettype none

`include "mem_defs.svh"

module memory_access_stage
	import isa_pkg::*, mem_pkg::*;
#(
	parameter logic [`MEM_CORE_ID_BITS-1:0] CORE_ID = '0
)
(
	input  logic						clk,
	input  logic						arst_n_i,
	input  logic						flush_i,
	input  instr_t						instruction_i,
	input  logic [1:0]					strand_i,
	input  logic [31:0]					pc_i,
	input  logic [`MEM_LINE_BITS-1:0]	store_value_i,
	input  logic [`MEM_LINE_BITS-1:0]	result_i,
	input  logic [`MEM_LANES-1:0]		mask_i,
	input  logic						has_writeback_i,
	input  logic [6:0]					writeback_reg_i,
	input  logic						writeback_is_vector_i,
	input  logic [3:0]					reg_lane_select_i,
	input  logic [31:0]					strided_offset_i,
	input  logic [31:0]					base_addr_i,
	output line_req_t					req_o,
	output logic						access_o,
	output logic						synchronized_o,
	output stage_out_t					stage_o,
	output logic [3:0]					strand_enable_o
);
	localparam int LINE_BITS = `MEM_LINE_BITS;
	localparam int LANES = `MEM_LANES;

	mem_op_e				op;
	logic					is_fmt_c;
	logic					is_cr;
	logic					is_block;
	logic					is_strided;
	logic					is_scatter;
	logic					lane_enabled;
	logic [8:0]				lane_lsb;
	logic [31:0]			lane_value;
	logic [31:0]			strided_ptr;
	logic [31:0]			scatter_ptr;
	logic [31:0]			addr_ptr;
	logic [3:0]				cache_lane;
	logic [3:0]				byte_mask;
	logic [31:0]			word_data;
	logic [LANES-1:0]		word_mask;
	logic [LINE_BITS-1:0]	swapped;
	logic [LINE_BITS-1:0]	line_data;
	logic [LINE_BITS/8-1:0]	write_mask;
	logic [LINE_BITS-1:0]	result_nxt;
	logic [31:0]			cr_value;
	logic [31:0]			test_cr7_q;

	function automatic logic [31:0] bswap32(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	assign op = instruction_i.op;
	assign is_fmt_c = instruction_i.format == FMT_C;
	assign is_cr = is_fmt_c && op == OP_WORD_CR;
	assign is_block = op inside {OP_BLOCK, OP_BLOCK_M, OP_BLOCK_IM};
	assign is_strided = op inside {OP_STRIDED, OP_STRIDED_M, OP_STRIDED_IM};
	assign is_scatter = op inside {OP_SCGATH, OP_SCGATH_M, OP_SCGATH_IM};

	// Lane 0 sits in the top word of a register
	assign lane_lsb = {~reg_lane_select_i, 5'd0};
	assign lane_value = store_value_i[lane_lsb +: 32];
	assign scatter_ptr = result_i[lane_lsb +: 32];
	assign lane_enabled = mask_i[~reg_lane_select_i];
	assign strided_ptr = base_addr_i + strided_offset_i;

	always_comb
	begin
		if (is_strided)
			addr_ptr = strided_ptr;
		else if (is_scatter)
			addr_ptr = scatter_ptr;
		else
			addr_ptr = result_i[31:0];	// Scalar and block
	end

	assign cache_lane = addr_ptr[5:2];

	always_comb
	begin
		for (int i = 0; i < LANES; i++)
			swapped[i*32 +: 32] = bswap32(store_value_i[i*32 +: 32]);
	end

	// Big-endian placement within the word, replicated to every lane
	always_comb
	begin
		byte_mask = 4'b1111;
		case (op)
			OP_BYTE_U, OP_BYTE_S:
			begin
				byte_mask = 4'b1000 >> result_i[1:0];
				word_data = {store_value_i[7:0], 24'd0} >> {result_i[1:0], 3'd0};
			end
			OP_HALF_U, OP_HALF_S:
			begin
				byte_mask = 4'b1100 >> {result_i[1], 1'b0};
				word_data = {store_value_i[7:0], store_value_i[15:8], 16'd0} >> {result_i[1], 4'd0};
			end
			OP_STRIDED, OP_STRIDED_M, OP_STRIDED_IM,
			OP_SCGATH, OP_SCGATH_M, OP_SCGATH_IM:
				word_data = bswap32(lane_value);
			default:
				word_data = bswap32(store_value_i[31:0]);
		endcase
		line_data = is_block ? swapped : {LANES{word_data}};
	end

	always_comb
	begin
		if (is_block)
			word_mask = mask_i;
		else if ((is_strided || is_scatter) && !lane_enabled)
			word_mask = '0;
		else
			word_mask = {1'b1, {(LANES-1){1'b0}}} >> cache_lane;
		for (int w = 0; w < LANES; w++)
			write_mask[w*4 +: 4] = word_mask[w] ? byte_mask : 4'b0000;
	end

	assign access_o = !flush_i && is_fmt_c && (is_block || (!is_cr && lane_enabled));
	assign synchronized_o = op == OP_WORD_SYNC;

	assign req_o = '{
		addr:	addr_ptr[31:6],
		write:	is_fmt_c && !instruction_i.load && !is_cr && !flush_i,
		mask:	write_mask,
		data:	line_data
	};

	// Control register read
	always_comb
	begin
		case (instruction_i.cr_index)
			CR_STRAND_ID:	cr_value = {CORE_ID, strand_i};
			CR_TEST:		cr_value = test_cr7_q;
			CR_STRAND_EN:	cr_value = {28'd0, strand_enable_o};
			default:		cr_value = '0;
		endcase
		result_nxt = is_cr ? LINE_BITS'(cr_value) : result_i;
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			test_cr7_q <= '0;
			strand_enable_o <= 4'b0001;
		end
		else if (!flush_i && is_cr && !instruction_i.load)
		begin
			case (instruction_i.cr_index)
				CR_TEST:		test_cr7_q <= store_value_i[31:0];
				CR_STRAND_EN:	strand_enable_o <= store_value_i[3:0];
				CR_HALT:		strand_enable_o <= '0;
				default:		;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			stage_o <= '0;
		else
		begin
			stage_o.instruction <= flush_i ? instr_t'('0) : instruction_i;
			stage_o.has_writeback <= has_writeback_i && !flush_i;
			stage_o.strand <= strand_i;
			stage_o.pc <= pc_i;
			stage_o.result <= result_nxt;
			stage_o.mask <= mask_i;
			stage_o.writeback_reg <= writeback_reg_i;
			stage_o.is_vector <= writeback_is_vector_i;
			stage_o.reg_lane <= reg_lane_select_i;
			stage_o.cache_lane <= cache_lane;
			stage_o.strided_offset <= strided_offset_i;
			stage_o.was_access <= access_o;
		end
	end

	// A flushed instruction leaves no trace in the next stage
	a_flush_quiet: assert property (@(posedge clk) disable iff (!arst_n_i)
		flush_i |=> !stage_o.was_access && !stage_o.has_writeback
			&& stage_o.instruction == instr_t'('0));
endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build the memory subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
	--top-module tb_mem_subsystem -o sim_tb > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -qF "*** FAILED ***" sim.log && { echo "Simulation failed"; exit 1; }
grep -qF "*** PASSED ***" sim.log || { echo "Simulation did not finish"; exit 1; }
echo "Simulation passed"

// File: tb_mem_subsystem.sv
/*
 * Memory subsystem testbench with a host-side reference line model and
 * scalar, block, strided, scatter, control register, flush and arbitration tests
 */
`default_nettype none

`include "mem_defs.svh"

module tb_mem_subsystem
	import isa_pkg::*, mem_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [`MEM_CORE_ID_BITS-1:0] CORE_ID = 30'h12c4_a5e1;
	localparam int LINE_BITS = `MEM_LINE_BITS;
	localparam int GNT_TIMEOUT = 32;
	localparam int RVALID_TIMEOUT = 4;
	localparam logic [31:0] SEED = 32'h256e94d3;

	logic					clk;
	logic					arst_n_i;
	logic					flush_i;
	instr_t					instruction_i;
	logic [1:0]				strand_i;
	logic [31:0]			pc_i;
	logic [LINE_BITS-1:0]	store_value_i;
	logic [LINE_BITS-1:0]	result_i;
	logic [`MEM_LANES-1:0]	mask_i;
	logic					has_writeback_i;
	logic [6:0]				writeback_reg_i;
	logic					writeback_is_vector_i;
	logic [3:0]				reg_lane_select_i;
	logic [31:0]			strided_offset_i;
	logic [31:0]			base_addr_i;
	line_req_t				req_o;
	logic					access_o;
	logic					synchronized_o;
	stage_out_t				stage_o;
	logic [3:0]				strand_enable_o;
	logic					host_req_i;
	line_req_t				host_line_i;
	logic					host_gnt_o;
	logic					host_rvalid_o;
	logic [LINE_BITS-1:0]	host_rdata_o;
	logic [LINE_BITS-1:0]	load_line_o;

	logic [LINE_BITS-1:0]	ref_mem [`MEM_DEPTH_LINES];	// Byte offset 0 is the top byte
	int						checks;
	int						errors;

	mem_subsystem #(.CORE_ID(CORE_ID)) dut (.*);

	always #10 clk = ~clk;

	function automatic logic [LINE_BITS-1:0] rand_line();
		logic [LINE_BITS-1:0] v;
		for (int i = 0; i < 16; i++)
			v[i*32 +: 32] = $urandom;
		return v;
	endfunction

	function automatic logic [LINE_BITS-1:0] fill_line(input logic [5:0] line);
		logic [LINE_BITS-1:0] v;
		for (int w = 0; w < 16; w++)
			v[w*32 +: 32] = 32'h9e3779b9 * {22'd0, line, w[3:0]} ^ 32'h5a5a_0f0f;
		return v;
	endfunction

	task automatic check(input string name, input logic [LINE_BITS-1:0] got,
		input logic [LINE_BITS-1:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("error: %s got %0h expected %0h", name, got, exp);
		end
	endtask

	task automatic put_bytes(input logic [5:0] line, input int off, input logic [31:0] v,
		input int n);
		for (int i = 0; i < n; i++)
			ref_mem[line][(63 - off - i)*8 +: 8] = v[i*8 +: 8];	// Little-endian value bytes
	endtask

	// Reference rules for one stage instruction
	task automatic model_op(input mem_op_e op, input bit load, input logic [LINE_BITS-1:0] sv,
		input logic [LINE_BITS-1:0] res, input logic [15:0] msk, input logic [3:0] sel,
		input logic [31:0] ofs, output bit acc, output logic [31:0] addr);
		logic [31:0]	a;
		logic [31:0]	lane_sv;
		logic [5:0]		line;
		int				ln;
		ln = 15 - int'(sel);	// Register lane 0 is the top word
		lane_sv = sv[ln*32 +: 32];
		a = res[31:0];
		if (op inside {OP_STRIDED, OP_STRIDED_M, OP_STRIDED_IM})
			a = base_addr_i + ofs;
		else if (op inside {OP_SCGATH, OP_SCGATH_M, OP_SCGATH_IM})
			a = res[ln*32 +: 32];
		addr = a;
		line = a[11:6];
		acc = 1'b0;
		if (flush_i || op == OP_WORD_CR)
			return;
		if (op inside {OP_BLOCK, OP_BLOCK_M, OP_BLOCK_IM})
		begin
			acc = 1'b1;
			for (int m = 0; m < 16 && !load; m++)
			begin
				if (msk[15-m])
					put_bytes(line, 4*m, sv[(15-m)*32 +: 32], 4);
			end
			return;
		end
		acc = msk[ln];
		if (!acc || load)
			return;
		case (op)
			OP_BYTE_U, OP_BYTE_S:	put_bytes(line, int'(a[5:0]), sv[31:0], 1);
			OP_HALF_U, OP_HALF_S:	put_bytes(line, int'({a[5:1], 1'b0}), sv[31:0], 2);
			OP_WORD, OP_WORD_SYNC:	put_bytes(line, int'({a[5:2], 2'b0}), sv[31:0], 4);
			default:				put_bytes(line, int'({a[5:2], 2'b0}), lane_sv, 4);
		endcase
	endtask

	// Starts and ends on a falling edge one cycle apart
	task automatic issue(input mem_op_e op, input bit load, input logic [4:0] cr,
		input logic [LINE_BITS-1:0] sv, input logic [LINE_BITS-1:0] res,
		input logic [15:0] msk, input logic [3:0] sel, input logic [31:0] ofs);
		bit				acc;
		logic [31:0]	addr;
		logic [5:0]		line;
		instruction_i = '0;
		instruction_i.format = FMT_C;
		instruction_i.load = load;
		instruction_i.op = op;
		instruction_i.cr_index = cr;
		store_value_i = sv;
		result_i = res;
		mask_i = msk;
		reg_lane_select_i = sel;
		strided_offset_i = ofs;
		pc_i = pc_i + 32'd4;
		writeback_reg_i = 7'($urandom);
		writeback_is_vector_i = !writeback_is_vector_i;
		model_op(op, load, sv, res, msk, sel, ofs, acc, addr);
		line = addr[11:6];
		@(posedge clk);
		check("access_o", 512'(access_o), 512'(acc));
		check("synchronized_o", 512'(synchronized_o), 512'(op == OP_WORD_SYNC));
		if (acc)
		begin
			check("req_o.addr", 512'(req_o.addr), 512'(addr[31:6]));
			check("req_o.write", 512'(req_o.write), 512'(!load));
		end
		@(negedge clk);
		check("stage_o.was_access", 512'(stage_o.was_access), 512'(acc));
		check("stage_o.instruction", 512'(stage_o.instruction),
			512'(flush_i ? instr_t'('0) : instruction_i));
		check("stage_o.has_writeback", 512'(stage_o.has_writeback),
			512'(has_writeback_i && !flush_i));
		check("stage_o.strand", 512'(stage_o.strand), 512'(strand_i));
		check("stage_o.pc", 512'(stage_o.pc), 512'(pc_i));
		check("stage_o.mask", 512'(stage_o.mask), 512'(msk));
		check("stage_o.writeback_reg", 512'(stage_o.writeback_reg), 512'(writeback_reg_i));
		check("stage_o.is_vector", 512'(stage_o.is_vector), 512'(writeback_is_vector_i));
		check("stage_o.reg_lane", 512'(stage_o.reg_lane), 512'(sel));
		check("stage_o.cache_lane", 512'(stage_o.cache_lane), 512'(addr[5:2]));
		check("stage_o.strided_offset", 512'(stage_o.strided_offset), 512'(ofs));
		if (acc && load)
			check("load_line_o", load_line_o, ref_mem[line]);
	endtask

	task automatic idle();
		instruction_i = '0;
	endtask

	task automatic host_access(input logic [5:0] line, input bit wr,
		input logic [LINE_BITS-1:0] data, output logic [LINE_BITS-1:0] rdata,
		output int waited);
		bit	granted;
		int	n;
		host_req_i = 1'b1;
		host_line_i = '0;
		host_line_i.addr = 26'(line);
		host_line_i.write = wr;
		host_line_i.mask = wr ? '1 : '0;
		host_line_i.data = data;
		granted = 1'b0;
		waited = 0;
		rdata = 'x;
		while (!granted && waited < GNT_TIMEOUT)
		begin
			@(posedge clk);
			granted = host_gnt_o;	// Depends on inputs only
			if (!granted)
				waited++;
		end
		@(negedge clk);
		host_req_i = 1'b0;
		if (!granted)
		begin
			errors++;
			$display("timeout: host request for line %0d was never granted", line);
			return;
		end
		n = 0;
		while (!host_rvalid_o && n < RVALID_TIMEOUT)
		begin
			n++;
			@(negedge clk);
		end
		if (!host_rvalid_o)
		begin
			errors++;
			$display("timeout: no read data for host line %0d", line);
			return;
		end
		check("host_rvalid_o delay", 512'(n), 512'(0));
		rdata = host_rdata_o;
	endtask

	task automatic check_line(input logic [5:0] line);
		logic [LINE_BITS-1:0]	rd;
		int						waited;
		host_access(line, 1'b0, '0, rd, waited);
		check($sformatf("host_rdata_o line %0d", line), rd, ref_mem[line]);
	endtask

	initial
	begin
		logic [LINE_BITS-1:0]	rd;
		logic [LINE_BITS-1:0]	res;
		logic [31:0]			a;
		logic [15:0]			msk;
		logic [3:0]				sel;
		mem_op_e				op;
		int						waited;
		void'($urandom(SEED));
		checks = 0;
		errors = 0;
		clk = 1'b0;
		arst_n_i = 1'b0;
		flush_i = 1'b0;
		instruction_i = '0;
		strand_i = 2'd0;
		pc_i = 32'h0000_1000;
		store_value_i = '0;
		result_i = '0;
		mask_i = '0;
		has_writeback_i = 1'b0;
		writeback_reg_i = 7'd0;
		writeback_is_vector_i = 1'b0;
		reg_lane_select_i = 4'd0;
		strided_offset_i = 32'd0;
		base_addr_i = 32'd0;
		host_req_i = 1'b0;
		host_line_i = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		arst_n_i = 1'b1;

		check("host_gnt_o", 512'(host_gnt_o), '0);
		check("host_rvalid_o", 512'(host_rvalid_o), '0);
		check("stage_o.was_access", 512'(stage_o.was_access), '0);
		check("stage_o.has_writeback", 512'(stage_o.has_writeback), '0);
		check("stage_o.instruction", 512'(stage_o.instruction), '0);
		check("strand_enable_o", 512'(strand_enable_o), 512'(4'b0001));

		for (int l = 0; l < `MEM_DEPTH_LINES; l++)
		begin
			ref_mem[l] = fill_line(6'(l));
			host_access(6'(l), 1'b1, ref_mem[l], rd, waited);
		end

		// Scalar stores followed by word loads of the same line
		for (int i = 0; i < 9; i++)
		begin
			case (i % 3)
				0:			op = (i % 2 == 1) ? OP_BYTE_S : OP_BYTE_U;
				1:			op = (i % 2 == 1) ? OP_HALF_S : OP_HALF_U;
				default:	op = (i % 2 == 1) ? OP_WORD_SYNC : OP_WORD;
			endcase
			a = $urandom;
			issue(op, 1'b0, 5'd0, rand_line(), 512'(a), 16'hffff, 4'd0, 32'd0);
			issue(OP_WORD, 1'b1, 5'd0, '0, 512'(a), 16'hffff, 4'd0, 32'd0);
			idle();
			check_line(a[11:6]);
		end

		for (int i = 0; i < 3; i++)
		begin
			op = (i == 0) ? OP_BLOCK : ((i == 1) ? OP_BLOCK_M : OP_BLOCK_IM);
			a = $urandom & 32'hffff_ffc0;
			msk = 16'($urandom);
			issue(op, 1'b0, 5'd0, rand_line(), 512'(a), msk, 4'd0, 32'd0);
			issue(OP_BLOCK, 1'b1, 5'd0, '0, 512'(a), msk, 4'd0, 32'd0);
			idle();
			check_line(a[11:6]);
		end

		// Odd passes clear the selected lane's mask bit
		for (int i = 0; i < 4; i++)
		begin
			sel = 4'($urandom);
			msk = 16'($urandom);
			if (i % 2 == 1)
				msk = msk & ~(16'h8000 >> sel);
			else
				msk = msk | (16'h8000 >> sel);
			base_addr_i = $urandom;
			a = $urandom;
			issue(OP_STRIDED, 1'b0, 5'd0, rand_line(), '0, msk, sel, a);
			idle();
			a = base_addr_i + a;
			check_line(a[11:6]);
			res = rand_line();
			issue(OP_SCGATH_M, 1'b0, 5'd0, rand_line(), res, msk, sel, 32'd0);
			idle();
			a = res[(15 - int'(sel))*32 +: 32];
			check_line(a[11:6]);
		end

		has_writeback_i = 1'b1;
		a = $urandom;
		res = 512'(a);
		issue(OP_WORD_CR, 1'b0, CR_TEST, 512'(32'hc0de_7e57 ^ a), res, 16'hffff, 4'd0, 32'd0);
		issue(OP_WORD_CR, 1'b1, CR_TEST, '0, res, 16'hffff, 4'd0, 32'd0);
		check("stage_o.result cr7", stage_o.result, 512'(32'hc0de_7e57 ^ a));
		strand_i = 2'd2;
		issue(OP_WORD_CR, 1'b1, CR_STRAND_ID, '0, res, 16'hffff, 4'd0, 32'd0);
		check("stage_o.result cr0", stage_o.result, 512'({CORE_ID, 2'd2}));
		issue(OP_WORD_CR, 1'b0, CR_STRAND_EN, 512'(4'b1011), res, 16'hffff, 4'd0, 32'd0);
		check("strand_enable_o", 512'(strand_enable_o), 512'(4'b1011));
		issue(OP_WORD_CR, 1'b1, CR_STRAND_EN, '0, res, 16'hffff, 4'd0, 32'd0);
		check("stage_o.result cr30", stage_o.result, 512'(4'b1011));
		issue(OP_WORD_CR, 1'b0, CR_HALT, '0, res, 16'hffff, 4'd0, 32'd0);
		check("strand_enable_o", 512'(strand_enable_o), '0);
		idle();
		check_line(a[11:6]);

		flush_i = 1'b1;
		a = $urandom;
		issue(OP_WORD, 1'b0, 5'd0, rand_line(), 512'(a), 16'hffff, 4'd0, 32'd0);
		check("stage_o.instruction", 512'(stage_o.instruction), '0);
		check("stage_o.has_writeback", 512'(stage_o.has_writeback), '0);
		flush_i = 1'b0;
		has_writeback_i = 1'b0;
		idle();
		check_line(a[11:6]);

		// Host read of line 20 against five stage stores to line 10
		fork
			begin
				for (int k = 0; k < 5; k++)
					issue(OP_WORD, 1'b0, 5'd0, rand_line(),
						512'({20'($urandom), 6'd10, 6'($urandom)}), 16'hffff, 4'd0, 32'd0);
				idle();
			end
			begin
				host_access(6'd20, 1'b0, '0, rd, waited);
				check("host_gnt_o wait cycles", 512'(waited), 512'(5));
				check("host_rdata_o line 20", rd, ref_mem[20]);
			end
		join
		check_line(6'd10);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end
endmodule

`default_nettype wire
